// ==== common/rooth_defines.svh ====
`ifndef ROOTH_DEFINES_SVH
`define ROOTH_DEFINES_SVH

// datapath width
`define ROOTH_XLEN          32

// integer register file
`define ROOTH_REG_NUM       32
`define ROOTH_REG_ADDR_W    5

// one quotient bit per step
`define ROOTH_DIV_STEPS     32

`endif

// ==== common/rooth_pkg.sv ====
`include "rooth_defines.svh"

package rooth_pkg;

    typedef logic [`ROOTH_XLEN-1:0]       word_t;
    typedef logic [`ROOTH_REG_ADDR_W-1:0] reg_addr_t;

    // low two bits of a divide op match div_op_e
    typedef enum logic [2:0] {
        OP_DIV  = 3'd0,
        OP_DIVU = 3'd1,
        OP_REM  = 3'd2,
        OP_REMU = 3'd3,
        OP_LW   = 3'd4,
        OP_SW   = 3'd5
    } exec_op_e;

    typedef enum logic [1:0] {
        DOP_DIV  = 2'd0,
        DOP_DIVU = 2'd1,
        DOP_REM  = 2'd2,
        DOP_REMU = 2'd3
    } div_op_e;

endpackage

// ==== verilog/regs_file.sv ====
`timescale 1ns/1ps
`include "rooth_defines.svh"

module regs_file (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  rooth_pkg::reg_addr_t rs1_addr_i,
    input  rooth_pkg::reg_addr_t rs2_addr_i,
    output rooth_pkg::word_t     rs1_data_o,
    output rooth_pkg::word_t     rs2_data_o,
    input  rooth_pkg::reg_addr_t dbg_addr_i,
    output rooth_pkg::word_t     dbg_rdata_o,
    input  logic                 we_i,
    input  rooth_pkg::reg_addr_t waddr_i,
    input  rooth_pkg::word_t     wdata_i
);
    import rooth_pkg::*;

    // x0 has no storage
    word_t regs_q [1:`ROOTH_REG_NUM-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `ROOTH_REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rs1_data_o  = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o  = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];
    assign dbg_rdata_o = (dbg_addr_i == '0) ? '0 : regs_q[dbg_addr_i];

endmodule

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 dbg_we_i,
    input  rooth_pkg::reg_addr_t dbg_addr_i,
    input  rooth_pkg::word_t     dbg_wdata_i,
    input  logic                 div_wb_req_i,
    input  rooth_pkg::reg_addr_t div_wb_rd_i,
    input  rooth_pkg::word_t     div_wb_data_i,
    output logic                 div_wb_gnt_o,
    input  logic                 lsu_wb_req_i,
    input  rooth_pkg::reg_addr_t lsu_wb_rd_i,
    input  rooth_pkg::word_t     lsu_wb_data_i,
    output logic                 lsu_wb_gnt_o,
    output logic                 we_o,
    output rooth_pkg::reg_addr_t waddr_o,
    output rooth_pkg::word_t     wdata_o
);
    import rooth_pkg::*;

    // set when lsu wins the next tie
    logic prio_lsu_q;

    // debug write always wins
    assign div_wb_gnt_o = ~dbg_we_i & div_wb_req_i & (~lsu_wb_req_i | ~prio_lsu_q);
    assign lsu_wb_gnt_o = ~dbg_we_i & lsu_wb_req_i & (~div_wb_req_i | prio_lsu_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_lsu_q <= 1'b0;
        end else if (div_wb_gnt_o) begin
            prio_lsu_q <= 1'b1;
        end else if (lsu_wb_gnt_o) begin
            prio_lsu_q <= 1'b0;
        end
    end

    always_comb begin
        we_o    = dbg_we_i | div_wb_gnt_o | lsu_wb_gnt_o;
        waddr_o = dbg_addr_i;
        wdata_o = dbg_wdata_i;
        if (div_wb_gnt_o) begin
            waddr_o = div_wb_rd_i;
            wdata_o = div_wb_data_i;
        end else if (lsu_wb_gnt_o) begin
            waddr_o = lsu_wb_rd_i;
            wdata_o = lsu_wb_data_i;
        end
    end

    // a request waits unchanged for its grant
    a_div_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        (div_wb_req_i && !div_wb_gnt_o) |=>
            div_wb_req_i && $stable(div_wb_rd_i) && $stable(div_wb_data_i));

    a_lsu_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        (lsu_wb_req_i && !lsu_wb_gnt_o) |=>
            lsu_wb_req_i && $stable(lsu_wb_rd_i) && $stable(lsu_wb_data_i));

endmodule

// ==== verilog/issue_ctrl.sv ====
`timescale 1ns/1ps
`include "rooth_defines.svh"

module issue_ctrl (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 req_i,
    input  rooth_pkg::exec_op_e  op_i,
    input  rooth_pkg::reg_addr_t rs1_i,
    input  rooth_pkg::reg_addr_t rs2_i,
    input  rooth_pkg::reg_addr_t rd_i,
    input  rooth_pkg::word_t     imm_i,
    output logic                 ack_o,
    input  logic                 halt_i,
    output rooth_pkg::reg_addr_t rs1_addr_o,
    output rooth_pkg::reg_addr_t rs2_addr_o,
    input  rooth_pkg::word_t     rs1_data_i,
    input  rooth_pkg::word_t     rs2_data_i,
    output logic                 div_start_o,
    output rooth_pkg::div_op_e   div_op_o,
    output logic                 lsu_start_o,
    output logic                 lsu_we_o,
    output rooth_pkg::word_t     opa_o,
    output rooth_pkg::word_t     opb_o,
    output rooth_pkg::word_t     imm_o,
    output rooth_pkg::reg_addr_t rd_o,
    input  logic                 div_busy_i,
    input  logic                 lsu_busy_i,
    output logic                 busy_o
);
    import rooth_pkg::*;

    logic                      is_div;
    logic                      is_lsu;
    logic                      writes_rd;
    logic                      div_active;
    logic                      lsu_active;
    reg_addr_t                 div_rd_q;
    reg_addr_t                 lsu_rd_q;
    logic                      lsu_load_q;
    logic [`ROOTH_REG_NUM-1:0] pend_mask;
    logic                      clash;
    logic                      unit_free;
    logic                      accept;

    assign is_div    = op_i inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign is_lsu    = op_i inside {OP_LW, OP_SW};
    assign writes_rd = (op_i != OP_SW);

    // start covers the cycle before the unit raises busy
    assign div_active = div_start_o | div_busy_i;
    assign lsu_active = lsu_start_o | lsu_busy_i;

    // --------------------
    // scoreboard
    always_comb begin
        pend_mask = '0;
        if (div_active) begin
            pend_mask[div_rd_q] = 1'b1;
        end
        if (lsu_active && lsu_load_q) begin
            pend_mask[lsu_rd_q] = 1'b1;
        end
        pend_mask[0] = 1'b0;
    end

    assign clash     = pend_mask[rs1_i] | pend_mask[rs2_i] | (writes_rd & pend_mask[rd_i]);
    assign unit_free = (is_div & ~div_active) | (is_lsu & ~lsu_active);
    assign accept    = req_i & ~ack_o & ~halt_i & unit_free & ~clash;

    assign rs1_addr_o = rs1_i;
    assign rs2_addr_o = rs2_i;
    assign busy_o     = div_active | lsu_active | req_i | ack_o;

    // --------------------
    // handshake and dispatch
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o       <= 1'b0;
            div_start_o <= 1'b0;
            lsu_start_o <= 1'b0;
            div_rd_q    <= '0;
            lsu_rd_q    <= '0;
            lsu_load_q  <= 1'b0;
        end else begin
            div_start_o <= accept & is_div;
            lsu_start_o <= accept & is_lsu;
            if (accept) begin
                ack_o <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;
            end
            if (accept && is_div) begin
                div_rd_q <= rd_i;
            end
            if (accept && is_lsu) begin
                lsu_rd_q   <= rd_i;
                lsu_load_q <= (op_i == OP_LW);
            end
        end
    end

    // operands sampled in the accept cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            div_op_o <= div_op_e'(op_i[1:0]);
            lsu_we_o <= (op_i == OP_SW);
            opa_o    <= rs1_data_i;
            opb_o    <= rs2_data_i;
            imm_o    <= imm_i;
            rd_o     <= rd_i;
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(div_start_o && div_busy_i) && !(lsu_start_o && lsu_busy_i));

endmodule

// ==== div/div_unit.sv ====
`timescale 1ns/1ps
`include "rooth_defines.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  rooth_pkg::div_op_e   op_i,
    input  rooth_pkg::word_t     opa_i,
    input  rooth_pkg::word_t     opb_i,
    input  rooth_pkg::reg_addr_t rd_i,
    output logic                 busy_o,
    output logic                 wb_req_o,
    output rooth_pkg::reg_addr_t wb_rd_o,
    output rooth_pkg::word_t     wb_data_o,
    input  logic                 wb_gnt_i
);
    import rooth_pkg::*;

    localparam int CNT_W = $clog2(`ROOTH_DIV_STEPS);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIX, S_WB} state_e;

    state_e               state_q;
    logic [CNT_W-1:0]     cnt_q;
    logic [`ROOTH_XLEN:0] rem_q;
    logic [`ROOTH_XLEN:0] shift;
    logic [`ROOTH_XLEN:0] diff;
    word_t                quo_q;
    word_t                dvs_q;
    word_t                res;
    logic                 sgn_op;
    logic                 rem_op_q;
    logic                 neg_q_q;
    logic                 neg_r_q;

    assign busy_o   = (state_q != S_IDLE);
    assign wb_req_o = (state_q == S_WB);
    assign sgn_op   = (op_i == DOP_DIV) || (op_i == DOP_REM);

    // one restoring step
    assign shift = {rem_q[`ROOTH_XLEN-1:0], quo_q[`ROOTH_XLEN-1]};
    assign diff  = shift - {1'b0, dvs_q};

    assign res = rem_op_q ? (neg_r_q ? -rem_q[`ROOTH_XLEN-1:0] : rem_q[`ROOTH_XLEN-1:0])
                          : (neg_q_q ? -quo_q : quo_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (start_i) begin
                    state_q <= S_RUN;
                    cnt_q   <= '0;
                end
                S_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`ROOTH_DIV_STEPS - 1)) begin
                        state_q <= S_FIX;
                    end
                end
                S_FIX: state_q <= S_WB;
                S_WB: if (wb_gnt_i) begin
                    state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // divide by zero yields all ones and the dividend with no special case,
    // once the quotient sign is kept positive. min / -1 wraps to min itself
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) begin
            quo_q    <= (sgn_op && opa_i[`ROOTH_XLEN-1]) ? -opa_i : opa_i;
            dvs_q    <= (sgn_op && opb_i[`ROOTH_XLEN-1]) ? -opb_i : opb_i;
            rem_q    <= '0;
            rem_op_q <= (op_i == DOP_REM) || (op_i == DOP_REMU);
            neg_q_q  <= sgn_op && (opa_i[`ROOTH_XLEN-1] ^ opb_i[`ROOTH_XLEN-1])
                        && (opb_i != '0);
            neg_r_q  <= sgn_op && opa_i[`ROOTH_XLEN-1];
            wb_rd_o  <= rd_i;
        end else if (state_q == S_RUN) begin
            if (!diff[`ROOTH_XLEN]) begin
                rem_q <= diff;
                quo_q <= {quo_q[`ROOTH_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shift;
                quo_q <= {quo_q[`ROOTH_XLEN-2:0], 1'b0};
            end
        end else if (state_q == S_FIX) begin
            wb_data_o <= res;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !busy_o);

endmodule

// ==== lsu/lsu_unit.sv ====
`timescale 1ns/1ps

module lsu_unit (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  logic                 we_i,
    input  rooth_pkg::word_t     opa_i,
    input  rooth_pkg::word_t     opb_i,
    input  rooth_pkg::word_t     imm_i,
    input  rooth_pkg::reg_addr_t rd_i,
    output logic                 busy_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output rooth_pkg::word_t     mem_addr_o,
    output rooth_pkg::word_t     mem_wdata_o,
    input  logic                 mem_ack_i,
    input  rooth_pkg::word_t     mem_rdata_i,
    output logic                 wb_req_o,
    output rooth_pkg::reg_addr_t wb_rd_o,
    output rooth_pkg::word_t     wb_data_o,
    input  logic                 wb_gnt_i
);
    import rooth_pkg::*;

    typedef enum logic [1:0] {L_IDLE, L_MEM, L_WB} state_e;

    state_e state_q;

    assign busy_o    = (state_q != L_IDLE);
    assign mem_req_o = (state_q == L_MEM);
    assign wb_req_o  = (state_q == L_WB);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= L_IDLE;
        end else begin
            case (state_q)
                L_IDLE: if (start_i) begin
                    state_q <= L_MEM;
                end
                // store is done at the ack
                L_MEM: if (mem_ack_i) begin
                    state_q <= mem_we_o ? L_IDLE : L_WB;
                end
                L_WB: if (wb_gnt_i) begin
                    state_q <= L_IDLE;
                end
                default: state_q <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == L_IDLE && start_i) begin
            mem_addr_o  <= opa_i + imm_i;
            mem_we_o    <= we_i;
            mem_wdata_o <= opb_i;
            wb_rd_o     <= rd_i;
        end
        if (mem_req_o && mem_ack_i) begin
            wb_data_o <= mem_rdata_i;
        end
    end

    a_mem_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (mem_req_o && !mem_ack_i) |=>
            $stable(mem_addr_o) && $stable(mem_wdata_o) && $stable(mem_we_o));

endmodule

// ==== verilog/rooth_exec.sv ====
`timescale 1ns/1ps

module rooth_exec (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 req_i,
    input  rooth_pkg::exec_op_e  op_i,
    input  rooth_pkg::reg_addr_t rs1_i,
    input  rooth_pkg::reg_addr_t rs2_i,
    input  rooth_pkg::reg_addr_t rd_i,
    input  rooth_pkg::word_t     imm_i,
    output logic                 ack_o,
    output logic                 busy_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output rooth_pkg::word_t     mem_addr_o,
    output rooth_pkg::word_t     mem_wdata_o,
    input  logic                 mem_ack_i,
    input  rooth_pkg::word_t     mem_rdata_i,
    input  logic                 dbg_halt_i,
    input  logic                 dbg_we_i,
    input  rooth_pkg::reg_addr_t dbg_addr_i,
    input  rooth_pkg::word_t     dbg_wdata_i,
    output rooth_pkg::word_t     dbg_rdata_o
);
    import rooth_pkg::*;

    // issue side
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      div_start;
    div_op_e   div_op;
    logic      lsu_start;
    logic      lsu_we;
    word_t     opa;
    word_t     opb;
    word_t     imm;
    reg_addr_t rd;
    logic      div_busy;
    logic      lsu_busy;

    // write-back side
    logic      div_wb_req;
    reg_addr_t div_wb_rd;
    word_t     div_wb_data;
    logic      div_wb_gnt;
    logic      lsu_wb_req;
    reg_addr_t lsu_wb_rd;
    word_t     lsu_wb_data;
    logic      lsu_wb_gnt;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    issue_ctrl u_issue_ctrl_0 (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .req_i       ( req_i       ),
        .op_i        ( op_i        ),
        .rs1_i       ( rs1_i       ),
        .rs2_i       ( rs2_i       ),
        .rd_i        ( rd_i        ),
        .imm_i       ( imm_i       ),
        .ack_o       ( ack_o       ),
        .halt_i      ( dbg_halt_i  ),
        .rs1_addr_o  ( rs1_addr    ),
        .rs2_addr_o  ( rs2_addr    ),
        .rs1_data_i  ( rs1_data    ),
        .rs2_data_i  ( rs2_data    ),
        .div_start_o ( div_start   ),
        .div_op_o    ( div_op      ),
        .lsu_start_o ( lsu_start   ),
        .lsu_we_o    ( lsu_we      ),
        .opa_o       ( opa         ),
        .opb_o       ( opb         ),
        .imm_o       ( imm         ),
        .rd_o        ( rd          ),
        .div_busy_i  ( div_busy    ),
        .lsu_busy_i  ( lsu_busy    ),
        .busy_o      ( busy_o      )
    );

    regs_file u_regs_file_0 (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .rs1_addr_i  ( rs1_addr    ),
        .rs2_addr_i  ( rs2_addr    ),
        .rs1_data_o  ( rs1_data    ),
        .rs2_data_o  ( rs2_data    ),
        .dbg_addr_i  ( dbg_addr_i  ),
        .dbg_rdata_o ( dbg_rdata_o ),
        .we_i        ( rf_we       ),
        .waddr_i     ( rf_waddr    ),
        .wdata_i     ( rf_wdata    )
    );

    div_unit u_div_unit_0 (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .start_i     ( div_start   ),
        .op_i        ( div_op      ),
        .opa_i       ( opa         ),
        .opb_i       ( opb         ),
        .rd_i        ( rd          ),
        .busy_o      ( div_busy    ),
        .wb_req_o    ( div_wb_req  ),
        .wb_rd_o     ( div_wb_rd   ),
        .wb_data_o   ( div_wb_data ),
        .wb_gnt_i    ( div_wb_gnt  )
    );

    lsu_unit u_lsu_unit_0 (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .start_i     ( lsu_start   ),
        .we_i        ( lsu_we      ),
        .opa_i       ( opa         ),
        .opb_i       ( opb         ),
        .imm_i       ( imm         ),
        .rd_i        ( rd          ),
        .busy_o      ( lsu_busy    ),
        .mem_req_o   ( mem_req_o   ),
        .mem_we_o    ( mem_we_o    ),
        .mem_addr_o  ( mem_addr_o  ),
        .mem_wdata_o ( mem_wdata_o ),
        .mem_ack_i   ( mem_ack_i   ),
        .mem_rdata_i ( mem_rdata_i ),
        .wb_req_o    ( lsu_wb_req  ),
        .wb_rd_o     ( lsu_wb_rd   ),
        .wb_data_o   ( lsu_wb_data ),
        .wb_gnt_i    ( lsu_wb_gnt  )
    );

    wb_arbiter u_wb_arbiter_0 (
        .clk            ( clk         ),
        .arst_n_i       ( arst_n_i    ),
        .dbg_we_i       ( dbg_we_i    ),
        .dbg_addr_i     ( dbg_addr_i  ),
        .dbg_wdata_i    ( dbg_wdata_i ),
        .div_wb_req_i   ( div_wb_req  ),
        .div_wb_rd_i    ( div_wb_rd   ),
        .div_wb_data_i  ( div_wb_data ),
        .div_wb_gnt_o   ( div_wb_gnt  ),
        .lsu_wb_req_i   ( lsu_wb_req  ),
        .lsu_wb_rd_i    ( lsu_wb_rd   ),
        .lsu_wb_data_i  ( lsu_wb_data ),
        .lsu_wb_gnt_o   ( lsu_wb_gnt  ),
        .we_o           ( rf_we       ),
        .waddr_o        ( rf_waddr    ),
        .wdata_o        ( rf_wdata    )
    );

endmodule

// ==== tests/tb_rooth.sv ====
`timescale 1ns/1ps
`include "rooth_defines.svh"

module tb_rooth;
    import rooth_pkg::*;

    localparam int WAIT_LIMIT = 400;
    localparam int MEM_WORDS  = 64;

    logic      clk;
    logic      arst_n_i;
    logic      req_i;
    exec_op_e  op_i;
    reg_addr_t rs1_i;
    reg_addr_t rs2_i;
    reg_addr_t rd_i;
    word_t     imm_i;
    logic      ack_o;
    logic      busy_o;
    logic      mem_req_o;
    logic      mem_we_o;
    word_t     mem_addr_o;
    word_t     mem_wdata_o;
    logic      mem_ack_i   = 1'b0;
    word_t     mem_rdata_i = '0;
    logic      dbg_halt_i;
    logic      dbg_we_i;
    reg_addr_t dbg_addr_i;
    word_t     dbg_wdata_i;
    word_t     dbg_rdata_o;

    word_t       ref_regs [0:`ROOTH_REG_NUM-1];
    word_t       ref_mem  [0:MEM_WORDS-1];
    word_t       mem_q    [0:MEM_WORDS-1];
    logic [64:0] exp_acc_q [$];
    logic [15:0] stim_lfsr = 16'd55829;
    logic [15:0] mem_lfsr  = 16'd55829;
    int          mem_delay = -1;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_base = 0;
    exec_op_e    cur_op;
    reg_addr_t   cur_rs1;
    reg_addr_t   cur_rs2;
    reg_addr_t   cur_rd;
    word_t       cur_imm;

    rooth_exec dut (
        .clk(clk), .arst_n_i(arst_n_i),
        .req_i(req_i), .op_i(op_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .rd_i(rd_i),
        .imm_i(imm_i), .ack_o(ack_o), .busy_o(busy_o),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
        .dbg_halt_i(dbg_halt_i), .dbg_we_i(dbg_we_i), .dbg_addr_i(dbg_addr_i),
        .dbg_wdata_i(dbg_wdata_i), .dbg_rdata_o(dbg_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // random numbers, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        int    i;
        r = '0;
        for (i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            r = {r[30:0], stim_lfsr[0]};
        end
        return r;
    endfunction

    // zero, minus one and most negative come up often
    function automatic word_t pick_operand();
        case (rand_bits(3))
            0: return '0;
            1: return 32'hFFFF_FFFF;
            2: return 32'h8000_0000;
            3: return rand_bits(4);
            default: return rand_bits(32);
        endcase
    endfunction

    // --------------------
    // reference model
    function automatic word_t ref_div(input exec_op_e op, input word_t a, input word_t b);
        logic ovf;
        ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        case (op)
            OP_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
            OP_REMU: return (b == 0) ? a : a % b;
            OP_DIV: begin
                if (b == 0) return 32'hFFFF_FFFF;
                if (ovf) return a;
                return $signed(a) / $signed(b);
            end
            default: begin
                if (b == 0) return a;
                if (ovf) return '0;
                return $signed(a) % $signed(b);
            end
        endcase
    endfunction

    // offset that lands base + imm on word idx
    function automatic word_t offset_for(input reg_addr_t base, input logic [5:0] idx);
        return {24'b0, idx, 2'b00} - ref_regs[base];
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // --------------------
    // memory model
    always @(posedge clk) begin
        logic [64:0] acc;
        if (mem_ack_i) begin
            if (!mem_req_o) begin
                mem_ack_i <= 1'b0;
            end
        end else if (mem_req_o) begin
            if (mem_delay < 0) begin
                mem_lfsr  = lfsr_step(mem_lfsr);
                mem_delay = mem_lfsr[0];
                mem_lfsr  = lfsr_step(mem_lfsr);
                mem_delay = mem_delay * 2 + mem_lfsr[0];
            end
            if (mem_delay == 0) begin
                mem_delay = -1;
                if (exp_acc_q.size() == 0) begin
                    errors++;
                    $display("memory access at %0t that no operation asked for", $time);
                end else begin
                    acc = exp_acc_q.pop_front();
                    check_value("mem_we_o", mem_we_o, acc[64]);
                    check_value("mem_addr_o", mem_addr_o, acc[63:32]);
                    if (acc[64]) begin
                        check_value("mem_wdata_o", mem_wdata_o, acc[31:0]);
                    end
                end
                if (mem_we_o) begin
                    mem_q[mem_addr_o[7:2]] = mem_wdata_o;
                end else begin
                    mem_rdata_i <= mem_q[mem_addr_o[7:2]];
                end
                mem_ack_i <= 1'b1;
            end else begin
                mem_delay = mem_delay - 1;
            end
        end
    end

    // --------------------
    // bus tasks
    task automatic wait_ack(input logic level);
        int t;
        t = 0;
        @(negedge clk);
        while (ack_o !== level && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (ack_o !== level) begin
            errors++;
            $display("ack_o did not go to %0d within %0d cycles at %0t", level, WAIT_LIMIT,
                     $time);
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        @(negedge clk);
        while (busy_o !== 1'b0 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (busy_o !== 1'b0) begin
            errors++;
            $display("busy_o stayed high for %0d cycles at %0t", WAIT_LIMIT, $time);
        end
    endtask

    task automatic drive_req(input exec_op_e op, input reg_addr_t rs1, input reg_addr_t rs2,
                             input reg_addr_t rd, input word_t imm);
        cur_op  = op;
        cur_rs1 = rs1;
        cur_rs2 = rs2;
        cur_rd  = rd;
        cur_imm = imm;
        @(posedge clk);
        req_i <= 1'b1;
        op_i  <= op;
        rs1_i <= rs1;
        rs2_i <= rs2;
        rd_i  <= rd;
        imm_i <= imm;
    endtask

    // model follows issue order
    task automatic accept_req();
        word_t a;
        word_t b;
        word_t addr;
        wait_ack(1'b1);
        a    = ref_regs[cur_rs1];
        b    = ref_regs[cur_rs2];
        addr = a + cur_imm;
        case (cur_op)
            OP_LW: begin
                exp_acc_q.push_back({1'b0, addr, 32'h0});
                if (cur_rd != 0) ref_regs[cur_rd] = ref_mem[addr[7:2]];
            end
            OP_SW: begin
                exp_acc_q.push_back({1'b1, addr, b});
                ref_mem[addr[7:2]] = b;
            end
            default: if (cur_rd != 0) ref_regs[cur_rd] = ref_div(cur_op, a, b);
        endcase
        @(posedge clk);
        req_i <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic issue_op(input exec_op_e op, input reg_addr_t rs1, input reg_addr_t rs2,
                            input reg_addr_t rd, input word_t imm);
        drive_req(op, rs1, rs2, rd, imm);
        accept_req();
    endtask

    task automatic write_reg_dbg(input reg_addr_t a, input word_t d);
        @(posedge clk);
        dbg_we_i    <= 1'b1;
        dbg_addr_i  <= a;
        dbg_wdata_i <= d;
        @(posedge clk);
        dbg_we_i <= 1'b0;
        if (a != 0) ref_regs[a] = d;
    endtask

    task automatic compare_regs();
        int a;
        for (a = 0; a < `ROOTH_REG_NUM; a++) begin
            @(posedge clk);
            dbg_addr_i <= reg_addr_t'(a);
            @(negedge clk);
            check_value($sformatf("dbg_rdata_o x%0d", a), dbg_rdata_o, ref_regs[a]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (exp_acc_q.size() != 0) begin
            errors++;
            $display("%0d memory accesses never happened", exp_acc_q.size());
            exp_acc_q.delete();
        end
        if (errors != test_err_base) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - test_err_base);
        end else begin
            $display("test %s: ok", name);
        end
        test_err_base = errors;
    endtask

    // --------------------
    initial begin
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     sel;
        logic [5:0] idx;
        int        i;
        arst_n_i    <= 1'b0;
        req_i       <= 1'b0;
        op_i        <= OP_DIV;
        rs1_i       <= '0;
        rs2_i       <= '0;
        rd_i        <= '0;
        imm_i       <= '0;
        dbg_halt_i  <= 1'b0;
        dbg_we_i    <= 1'b0;
        dbg_addr_i  <= '0;
        dbg_wdata_i <= '0;
        for (i = 0; i < `ROOTH_REG_NUM; i++) ref_regs[i] = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem_q[i]   = 32'h9E37_79B9 * (i + 1) ^ {i[7:0], 24'h5A3C0F};
            ref_mem[i] = mem_q[i];
        end
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;

        @(negedge clk);
        check_value("ack_o", ack_o, 0);
        check_value("mem_req_o", mem_req_o, 0);
        check_value("busy_o", busy_o, 0);
        compare_regs();
        end_test("reset");

        for (i = 0; i < `ROOTH_REG_NUM; i++) write_reg_dbg(reg_addr_t'(i), rand_bits(32));
        compare_regs();
        end_test("debug");

        repeat (6) begin
            for (i = 1; i < `ROOTH_REG_NUM; i++) write_reg_dbg(reg_addr_t'(i), pick_operand());
            repeat (8) begin
                issue_op(exec_op_e'(rand_bits(2)), reg_addr_t'(rand_bits(5)),
                         reg_addr_t'(rand_bits(5)), reg_addr_t'(rand_bits(5)), '0);
            end
            wait_idle();
            compare_regs();
        end
        end_test("divide");

        repeat (12) begin
            idx = rand_bits(6);
            rs1 = rand_bits(5);
            issue_op(OP_SW, rs1, reg_addr_t'(rand_bits(5)), '0, offset_for(rs1, idx));
            rs1 = rand_bits(5);
            issue_op(OP_LW, rs1, '0, reg_addr_t'(rand_bits(5)), offset_for(rs1, idx));
        end
        wait_idle();
        compare_regs();
        end_test("store_load");

        // few registers, so most operations depend on each other
        repeat (40) begin
            sel = rand_bits(3);
            rs1 = rand_bits(3);
            rs2 = rand_bits(3);
            if (sel < 4) begin
                issue_op(exec_op_e'(sel[1:0]), rs1, rs2, reg_addr_t'(rand_bits(3)), '0);
            end else begin
                issue_op(sel[0] ? OP_SW : OP_LW, rs1, rs2, reg_addr_t'(rand_bits(3)),
                         offset_for(rs1, rand_bits(6)));
            end
        end
        wait_idle();
        compare_regs();
        for (i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("mem[%0d]", i), mem_q[i], ref_mem[i]);
        end
        end_test("mix");

        @(posedge clk);
        dbg_halt_i <= 1'b1;
        drive_req(OP_DIVU, reg_addr_t'(rand_bits(5)), reg_addr_t'(rand_bits(5)), 5'd9, '0);
        repeat (20) begin
            @(negedge clk);
            check_value("ack_o under halt", ack_o, 0);
        end
        @(posedge clk);
        dbg_halt_i <= 1'b0;
        accept_req();
        wait_idle();
        compare_regs();
        end_test("halt");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/rooth_pkg.sv
verilog/regs_file.sv
verilog/wb_arbiter.sv
verilog/issue_ctrl.sv
div/div_unit.sv
lsu/lsu_unit.sv
verilog/rooth_exec.sv
tests/tb_rooth.sv

// ==== Bender.yml ====
package:
  name: rooth_exec

sources:
  - include_dirs:
      - common
    files:
      - common/rooth_pkg.sv
      - verilog/regs_file.sv
      - verilog/wb_arbiter.sv
      - verilog/issue_ctrl.sv
      - div/div_unit.sv
      - lsu/lsu_unit.sv
      - verilog/rooth_exec.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_rooth.sv
